/* design/accel_pkg.sv */
`default_nettype none

package accel_pkg;

  localparam int accel_count    = 4;
  localparam int accel_id_width = 2;
  localparam int len_width      = 14;
  localparam int mem_addr_width = 8;  // Byte address, memory lines are 16 bytes
  localparam int line_width     = 128;
  localparam int io_addr_width  = 9;
  localparam int io_data_width  = 32;

  // Key bit 0 of the Toeplitz stream is the MSB of this constant
  localparam logic [319:0] hash_key =
    320'h6d5a56da255b0ec24167253d43a38fb0d0ca2bcbae7b30b477cb2da38030f20c6a42b73bbeac01fa;

  localparam int hash_space_bit   = 8;
  localparam int status_space_bit = 7;

  localparam logic [1:0] hash_word_clear = 2'd0;
  localparam logic [1:0] hash_word_feed1 = 2'd1;
  localparam logic [1:0] hash_word_feed2 = 2'd2;
  localparam logic [1:0] hash_word_feed4 = 2'd3;

  localparam logic [1:0] reg_ctrl = 2'd0;
  localparam logic [1:0] reg_len  = 2'd1;
  localparam logic [1:0] reg_addr = 2'd2;

  localparam int ctrl_start_bit = 0;
  localparam int ctrl_busy_bit  = 1;
  localparam int ctrl_stop_bit  = 4;
  localparam int ctrl_done_bit  = 8;
  localparam int ctrl_match_bit = 9;

  typedef struct packed {
    logic [accel_id_width-1:0] accel_id;
    logic [mem_addr_width-1:0] addr;
    logic [len_width-1:0]      len;
  } dma_desc_t;

  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } byte_beat_t;

  // Count 0 stands for a full word of 4 bytes
  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  count;
  } hash_word_t;

endpackage

`default_nettype wire

/* design/accel_rd_dma.sv */
`timescale 1ns/1ps
`default_nettype none

module accel_rd_dma #(
  parameter int bytes_per_line = 16,
  localparam int offset_width = $clog2(bytes_per_line),
  localparam int line_addr_width = accel_pkg::mem_addr_width - offset_width
) (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire accel_pkg::dma_desc_t            desc,
  input  wire                                  desc_valid,
  input  wire [accel_pkg::accel_count-1:0]     stop,
  output logic                                 busy,
  output logic [accel_pkg::accel_id_width-1:0] active_id,
  output logic                                 mem_rd_en,
  output logic [line_addr_width-1:0]           mem_rd_addr,
  input  wire [bytes_per_line*8-1:0]           mem_rd_data,
  output accel_pkg::byte_beat_t                beat,
  output logic [accel_pkg::accel_count-1:0]    beat_valid
);

  logic [bytes_per_line*8-1:0]     line_buf;
  logic [bytes_per_line*8-1:0]     cur_line;
  logic [offset_width-1:0]         byte_idx;
  logic [accel_pkg::len_width-1:0] remaining;
  logic                            resp_valid;  // A line is on mem_rd_data this cycle
  logic                            streaming;
  logic                            abort;
  logic                            emit;
  logic                            last;
  logic                            line_end;
  logic                            fetch_next;

  assign abort    = busy && stop[active_id];
  assign emit     = busy && (resp_valid || streaming) && !abort;
  assign last     = remaining == 1;
  assign line_end = &byte_idx;

  // The next line is requested two bytes before the current one runs out
  // When the first byte already ends its line the request follows the first read at once
  assign fetch_next = busy && !abort &&
                      (emit ? (byte_idx == offset_width'(bytes_per_line - 2) && remaining > 2)
                            : (line_end && remaining > 1));

  // A fresh line is used in the cycle it arrives, which keeps the stream gapless
  assign cur_line = resp_valid ? (mem_rd_data >> {byte_idx, 3'b000}) : line_buf;

  assign beat.data = cur_line[7:0];
  assign beat.last = last;

  always_comb begin
    beat_valid            = '0;
    beat_valid[active_id] = emit;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      streaming  <= 1'b0;
      mem_rd_en  <= 1'b0;
      resp_valid <= 1'b0;
      active_id  <= '0;
    end else begin
      mem_rd_en  <= fetch_next;
      resp_valid <= mem_rd_en;
      if (!busy) begin
        if (desc_valid && desc.len != '0) begin
          busy      <= 1'b1;
          mem_rd_en <= 1'b1;  // First line goes out with busy
          active_id <= desc.accel_id;
        end
      end else if (abort) begin
        busy      <= 1'b0;
        streaming <= 1'b0;
      end else if (emit) begin
        streaming <= 1'b1;
        if (last) begin
          busy      <= 1'b0;
          streaming <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && desc_valid) begin
      remaining   <= desc.len;
      mem_rd_addr <= desc.addr[accel_pkg::mem_addr_width-1:offset_width];
      byte_idx    <= desc.addr[offset_width-1:0];
    end else begin
      if (emit) begin
        remaining <= remaining - 1'b1;
        byte_idx  <= byte_idx + 1'b1;
        line_buf  <= cur_line >> 8;
      end
      if (fetch_next) begin
        mem_rd_addr <= mem_rd_addr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/accel_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module accel_regs (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire                                  io_en,
  input  wire                                  io_wen,
  input  wire [accel_pkg::io_addr_width-1:0]   io_addr,
  input  wire [accel_pkg::io_data_width-1:0]   io_wr_data,
  output logic [accel_pkg::io_data_width-1:0]  io_rd_data,
  output logic                                 io_rd_valid,
  output accel_pkg::dma_desc_t                 desc,
  output logic                                 desc_valid,
  output logic [accel_pkg::accel_count-1:0]    stop,
  input  wire                                  busy,
  input  wire [accel_pkg::accel_id_width-1:0]  active_id,
  input  wire [accel_pkg::accel_count-1:0]     beat_valid,
  input  wire                                  beat_last,
  input  wire [accel_pkg::accel_count-1:0]     match,
  output logic [accel_pkg::accel_count-1:0]    init,
  output accel_pkg::hash_word_t                hash_in,
  output logic                                 hash_valid,
  output logic                                 hash_clear,
  input  wire [31:0]                           hash_value
);

  logic [accel_pkg::len_width-1:0]      len_regs [accel_pkg::accel_count];
  logic [accel_pkg::mem_addr_width-1:0] addr_regs [accel_pkg::accel_count];
  logic [accel_pkg::accel_count-1:0]    status_done;
  logic [accel_pkg::accel_count-1:0]    status_match;
  logic                                 hash_rd_stall;
  logic                                 wr_req;
  logic                                 rd_req;
  logic                                 hash_sel;
  logic                                 status_sel;
  logic [1:0]                           word;
  logic [accel_pkg::accel_id_width-1:0] sel;

  assign wr_req     = io_en && io_wen;
  assign rd_req     = io_en && !io_wen;
  assign hash_sel   = io_addr[accel_pkg::hash_space_bit];
  assign status_sel = io_addr[accel_pkg::status_space_bit];
  assign word       = io_addr[3:2];
  assign sel        = io_addr[5:4];  // Matcher index

  always_ff @(posedge clk) begin
    if (rst) begin
      desc_valid <= 1'b0;
      stop       <= '0;
      init       <= '0;
      hash_valid <= 1'b0;
      hash_clear <= 1'b0;
    end else begin
      desc_valid <= 1'b0;
      stop       <= '0;
      init       <= '0;
      hash_valid <= 1'b0;
      hash_clear <= 1'b0;
      if (wr_req && hash_sel) begin
        hash_clear <= word == accel_pkg::hash_word_clear;
        hash_valid <= word != accel_pkg::hash_word_clear;
      end else if (wr_req && !status_sel && word == accel_pkg::reg_ctrl) begin
        // A start while a job runs is dropped along with its status clear
        if (io_wr_data[accel_pkg::ctrl_start_bit] && !busy) begin
          desc_valid <= 1'b1;
          init[sel]  <= 1'b1;
        end
        stop[sel] <= io_wr_data[accel_pkg::ctrl_stop_bit];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_req && hash_sel) begin
      hash_in.data <= io_wr_data;
      case (word)
        accel_pkg::hash_word_feed1: hash_in.count <= 2'd1;
        accel_pkg::hash_word_feed2: hash_in.count <= 2'd2;
        accel_pkg::hash_word_feed4: hash_in.count <= 2'd0;
        default: ;
      endcase
    end
    if (wr_req && !hash_sel && !status_sel) begin
      case (word)
        accel_pkg::reg_ctrl: begin
          desc.accel_id <= sel;
          desc.addr     <= addr_regs[sel];
          desc.len      <= len_regs[sel];
        end
        accel_pkg::reg_len:  len_regs[sel] <= io_wr_data[accel_pkg::len_width-1:0];
        accel_pkg::reg_addr: addr_regs[sel] <= io_wr_data[accel_pkg::mem_addr_width-1:0];
        default: ;
      endcase
    end
  end

  // Sticky status, a stop also counts as done
  always_ff @(posedge clk) begin
    if (rst) begin
      status_done  <= '0;
      status_match <= '0;
    end else begin
      status_done  <= (status_done | stop |
                       (beat_valid & {accel_pkg::accel_count{beat_last}})) & ~init;
      status_match <= (status_match | match) & ~init;
    end
  end

  // The hash unit needs one more cycle to absorb a feed that is still in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      io_rd_valid   <= 1'b0;
      hash_rd_stall <= 1'b0;
    end else begin
      io_rd_valid   <= hash_rd_stall || (rd_req && !(hash_sel && hash_valid));
      hash_rd_stall <= rd_req && hash_sel && hash_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (hash_rd_stall) begin
      io_rd_data <= hash_value;
    end else if (rd_req) begin
      io_rd_data <= '0;
      if (hash_sel) begin
        io_rd_data <= hash_value;
      end else if (status_sel) begin
        io_rd_data[accel_pkg::accel_count-1:0] <= status_done | status_match;
      end else begin
        case (word)
          accel_pkg::reg_ctrl: begin
            io_rd_data[accel_pkg::ctrl_busy_bit]  <= busy && active_id == sel;
            io_rd_data[accel_pkg::ctrl_done_bit]  <= status_done[sel];
            io_rd_data[accel_pkg::ctrl_match_bit] <= status_match[sel];
          end
          accel_pkg::reg_len:  io_rd_data[accel_pkg::len_width-1:0] <= len_regs[sel];
          accel_pkg::reg_addr: io_rd_data[accel_pkg::mem_addr_width-1:0] <= addr_regs[sel];
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* design/accel_wrap.sv */
`timescale 1ns/1ps
`default_nettype none

module accel_wrap #(
  parameter int bytes_per_line = accel_pkg::line_width / 8,
  parameter logic [63:0] pattern_0 = "GET ",
  parameter int pattern_len_0 = 4,
  parameter logic [63:0] pattern_1 = "HTTP/1.1",
  parameter int pattern_len_1 = 8,
  parameter logic [63:0] pattern_2 = "passwd",
  parameter int pattern_len_2 = 6,
  parameter logic [63:0] pattern_3 = "SSH-2.0",
  parameter int pattern_len_3 = 7,
  localparam int line_addr_width = accel_pkg::mem_addr_width - $clog2(bytes_per_line)
) (
  input  wire                                 clk,
  input  wire                                 rst,
  input  wire                                 io_en,
  input  wire                                 io_wen,
  input  wire [accel_pkg::io_addr_width-1:0]  io_addr,
  input  wire [accel_pkg::io_data_width-1:0]  io_wr_data,
  output logic [accel_pkg::io_data_width-1:0] io_rd_data,
  output logic                                io_rd_valid,
  output logic                                mem_rd_en,
  output logic [line_addr_width-1:0]          mem_rd_addr,
  input  wire [bytes_per_line*8-1:0]          mem_rd_data
);

  // Patterns are right-aligned in 64 bits, one slot per matcher
  localparam logic [accel_pkg::accel_count-1:0][63:0] patterns =
    {pattern_3, pattern_2, pattern_1, pattern_0};
  localparam logic [accel_pkg::accel_count-1:0][7:0] pattern_lens =
    {8'(pattern_len_3), 8'(pattern_len_2), 8'(pattern_len_1), 8'(pattern_len_0)};

  accel_pkg::dma_desc_t                 desc;
  logic                                 desc_valid;
  logic [accel_pkg::accel_count-1:0]    stop;
  logic [accel_pkg::accel_count-1:0]    init;
  logic                                 busy;
  logic [accel_pkg::accel_id_width-1:0] active_id;
  accel_pkg::byte_beat_t                beat;
  logic [accel_pkg::accel_count-1:0]    beat_valid;
  logic [accel_pkg::accel_count-1:0]    match;
  accel_pkg::hash_word_t                hash_in;
  logic                                 hash_valid;
  logic                                 hash_clear;
  logic [31:0]                          hash_value;

  accel_regs u_regs (
    .clk(clk), .rst(rst),
    .io_en(io_en), .io_wen(io_wen), .io_addr(io_addr), .io_wr_data(io_wr_data),
    .io_rd_data(io_rd_data), .io_rd_valid(io_rd_valid),
    .desc(desc), .desc_valid(desc_valid), .stop(stop),
    .busy(busy), .active_id(active_id),
    .beat_valid(beat_valid), .beat_last(beat.last), .match(match), .init(init),
    .hash_in(hash_in), .hash_valid(hash_valid), .hash_clear(hash_clear),
    .hash_value(hash_value)
  );

  accel_rd_dma #(.bytes_per_line(bytes_per_line)) u_dma (
    .clk(clk), .rst(rst),
    .desc(desc), .desc_valid(desc_valid), .stop(stop),
    .busy(busy), .active_id(active_id),
    .mem_rd_en(mem_rd_en), .mem_rd_addr(mem_rd_addr), .mem_rd_data(mem_rd_data),
    .beat(beat), .beat_valid(beat_valid)
  );

  for (genvar i = 0; i < accel_pkg::accel_count; i++) begin : g_matcher
    pattern_matcher #(
      .pattern_len(int'(pattern_lens[i])),
      .pattern(patterns[i][int'(pattern_lens[i])*8-1:0])
    ) u_matcher (
      .clk(clk), .rst(rst), .init(init[i]),
      .beat(beat), .beat_valid(beat_valid[i]), .match(match[i])
    );
  end

  toeplitz_hash u_hash (
    .clk(clk), .rst(rst),
    .hash_in(hash_in), .hash_valid(hash_valid), .hash_clear(hash_clear),
    .hash_value(hash_value)
  );

endmodule

`default_nettype wire

/* design/pattern_matcher.sv */
`timescale 1ns/1ps
`default_nettype none

module pattern_matcher #(
  parameter int pattern_len = 4,
  parameter logic [pattern_len*8-1:0] pattern = '0
) (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        init,
  input  wire accel_pkg::byte_beat_t beat,
  input  wire                        beat_valid,
  output logic                       match
);

  // The oldest byte sits at the top, in the same order as a string literal
  logic [pattern_len*8-1:0] history;
  logic [pattern_len*8-1:0] next_history;
  logic [pattern_len-1:0]   filled;
  logic [pattern_len-1:0]   next_filled;

  assign next_history = (history << 8) | beat.data;
  assign next_filled  = (filled << 1) | 1'b1;

  always_ff @(posedge clk) begin
    if (rst || init) begin
      filled <= '0;
      match  <= 1'b0;
    end else begin
      match <= beat_valid && (&next_filled) && next_history == pattern;
      if (beat_valid) begin
        filled <= beat.last ? '0 : next_filled;  // Jobs never share history
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat_valid) begin
      history <= next_history;
    end
  end

endmodule

`default_nettype wire

/* design/toeplitz_hash.sv */
`timescale 1ns/1ps
`default_nettype none

module toeplitz_hash (
  input  wire                        clk,
  input  wire                        rst,
  input  wire accel_pkg::hash_word_t hash_in,
  input  wire                        hash_valid,
  input  wire                        hash_clear,
  output logic [31:0]                hash_value
);

  localparam int max_pos = 288;  // Last window that still fits in the key

  logic [8:0]  pos;
  logic [8:0]  next_pos;
  logic [31:0] next_hash;
  logic [31:0] aligned;
  logic [5:0]  nbits;

  // The fed bytes are the low nbits of the word, taken MSB first
  assign nbits   = (hash_in.count == 2'd0) ? 6'd32 : {1'b0, hash_in.count, 3'b000};
  assign aligned = hash_in.data << (6'd32 - nbits);

  always_comb begin
    int unsigned p;
    next_hash = hash_value;
    for (int i = 0; i < 32; i++) begin
      p = pos + i;
      if (p > max_pos) begin
        p = max_pos;
      end
      if (aligned[31 - i]) begin
        next_hash = next_hash ^ accel_pkg::hash_key[319 - p -: 32];
      end
    end
    if (int'(pos) + int'(nbits) > max_pos) begin
      next_pos = 9'(max_pos);
    end else begin
      next_pos = pos + 9'(nbits);
    end
  end

  always_ff @(posedge clk) begin
    if (rst || hash_clear) begin
      hash_value <= '0;
      pos        <= '0;
    end else if (hash_valid) begin
      hash_value <= next_hash;
      pos        <= next_pos;
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module accel_wrap_tb -f verilog.f -o accel_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/accel_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
fi

if [ $run_status -eq 0 ] && grep -qx "Simulation completed successfully" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

/* test/accel_wrap_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module accel_wrap_tb;

  localparam int test_count      = 5;
  localparam int cycles_per_test = 2000;
  localparam logic [63:0] pat_0 = "GET ";
  localparam logic [63:0] pat_2 = "passwd";

  logic         clk = 1'b0;
  logic         rst = 1'b1;
  logic         io_en;
  logic         io_wen;
  logic [8:0]   io_addr;
  logic [31:0]  io_wr_data;
  logic [31:0]  io_rd_data;
  logic         io_rd_valid;
  logic         mem_rd_en;
  logic [3:0]   mem_rd_addr;
  logic [127:0] mem_rd_data = '0;

  logic [7:0] mem_bytes [256];
  logic [7:0] fed_bytes [64];
  logic       rd_pending = 1'b0;
  logic [3:0] rd_addr_q = '0;
  int         line_reads = 0;
  int         beats_seen = 0;
  integer     seed = 16;
  logic [3:0] exp_done = '0;
  logic [3:0] exp_match = '0;

  accel_wrap #(
    .bytes_per_line(16),
    .pattern_0(pat_0), .pattern_len_0(4),
    .pattern_1("HTTP/1.1"), .pattern_len_1(8),
    .pattern_2(pat_2), .pattern_len_2(6),
    .pattern_3("SSH-2.0"), .pattern_len_3(7)
  ) dut_i (
    .clk(clk), .rst(rst),
    .io_en(io_en), .io_wen(io_wen), .io_addr(io_addr), .io_wr_data(io_wr_data),
    .io_rd_data(io_rd_data), .io_rd_valid(io_rd_valid),
    .mem_rd_en(mem_rd_en), .mem_rd_addr(mem_rd_addr), .mem_rd_data(mem_rd_data)
  );

  always #4 clk = ~clk;

  function automatic logic [127:0] line_of(input logic [3:0] la);
    logic [127:0] line;
    for (int j = 0; j < 16; j++) begin
      line[8*j +: 8] = mem_bytes[{la, 4'(j)}];  // Byte 0 of a line sits in the low bits
    end
    line_of = line;
  endfunction

  // Memory answers one cycle after the request, and the stream is counted here too
  always @(negedge clk) begin
    if (rd_pending) begin
      mem_rd_data <= line_of(rd_addr_q);
    end
    rd_pending <= mem_rd_en;
    rd_addr_q  <= mem_rd_addr;
    if (mem_rd_en) begin
      line_reads <= line_reads + 1;
    end
    if (|dut_i.beat_valid) begin
      beats_seen <= beats_seen + 1;
    end
  end

  initial begin
    repeat (test_count * cycles_per_test) @(posedge clk);
    $display("Watchdog timeout, the tests did not finish in time");
    $display("Simulation failed");
    $fatal(1);
  end

  function automatic logic [8:0] matcher_reg(input int m, input int word);
    matcher_reg = 9'(m * 16 + word * 4);
  endfunction

  function automatic logic [31:0] ctrl_word(input logic done, input logic match);
    ctrl_word = '0;
    ctrl_word[8] = done;
    ctrl_word[9] = match;
  endfunction

  function automatic int line_span(input int addr, input int len);
    line_span = (addr + len - 1) / 16 - addr / 16 + 1;
  endfunction

  // Looks for the pattern anywhere in len bytes from start, the memory wraps at 256
  function automatic logic range_has_pattern(input int start, input int len,
                                             input logic [63:0] pat, input int plen);
    logic hit;
    logic found;
    found = 1'b0;
    for (int i = 0; i + plen <= len; i++) begin
      hit = 1'b1;
      for (int j = 0; j < plen; j++) begin
        if (mem_bytes[(start + i + j) % 256] != pat[8*(plen-1-j) +: 8]) begin
          hit = 1'b0;
        end
      end
      found = found | hit;
    end
    range_has_pattern = found;
  endfunction

  function automatic logic [31:0] toeplitz_ref(input int nbytes);
    logic [31:0] h;
    int          pos;
    h = '0;
    pos = 0;
    for (int b = 0; b < nbytes; b++) begin
      for (int k = 7; k >= 0; k--) begin
        if (fed_bytes[b][k]) begin
          h = h ^ accel_pkg::hash_key[319 - pos -: 32];
        end
        if (pos < 288) begin
          pos++;
        end
      end
    end
    toeplitz_ref = h;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic write_reg(input logic [8:0] addr, input logic [31:0] data);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_addr    = addr;
    io_wr_data = data;
    @(negedge clk);
    io_en  = 1'b0;
    io_wen = 1'b0;
  endtask

  task automatic read_reg(input logic [8:0] addr, output logic [31:0] data);
    int waited;
    waited  = 0;
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = addr;
    @(negedge clk);
    io_en = 1'b0;
    while (!io_rd_valid && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (!io_rd_valid) begin
      $display("Register read at address %h got no response", addr);
      $display("Simulation failed");
      $fatal(1);
    end else begin
      data = io_rd_data;
    end
  endtask

  task automatic wait_idle(input int m);
    logic [31:0] rd;
    int          polls;
    polls = 0;
    read_reg(matcher_reg(m, 0), rd);
    while (rd[1] && polls < 4000) begin
      read_reg(matcher_reg(m, 0), rd);
      polls++;
    end
    if (rd[1]) begin
      $display("Matcher %0d stayed busy and never finished its job", m);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic run_job(input int m, input int addr, input int len,
                         output int reads, output int beats);
    int reads0;
    int beats0;
    reads0 = line_reads;
    beats0 = beats_seen;
    write_reg(matcher_reg(m, 1), 32'(len));
    write_reg(matcher_reg(m, 2), 32'(addr));
    write_reg(matcher_reg(m, 0), 32'h1);
    @(negedge clk);  // Busy rises two cycles after the start write
    wait_idle(m);
    reads = line_reads - reads0;
    beats = beats_seen - beats0;
  endtask

  task automatic check_dma_job(input int addr, input int len, input string what);
    logic [31:0] rd;
    logic        hit;
    int          reads;
    int          beats;
    hit = range_has_pattern(addr, len, pat_2, 6);
    run_job(2, addr, len, reads, beats);
    read_reg(matcher_reg(2, 0), rd);
    check(rd, ctrl_word(1'b1, hit), {what, " status"});
    check(32'(reads), 32'(line_span(addr, len)), {what, " line reads"});
    check(32'(beats), 32'(len), {what, " bytes streamed"});
    exp_done[2]  = 1'b1;
    exp_match[2] = hit;
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] data;
    int          kind;
    int          nfed;
    int          beats0;
    int          beats;
    io_en      = 1'b0;
    io_wen     = 1'b0;
    io_addr    = '0;
    io_wr_data = '0;
    for (int a = 0; a < 256; a++) begin
      mem_bytes[a] = 8'($random(seed));
    end
    for (int j = 0; j < 6; j++) begin
      mem_bytes[60 + j] = pat_2[8*(5-j) +: 8];
    end
    for (int j = 0; j < 4; j++) begin
      mem_bytes[40 + j] = pat_0[8*(3-j) +: 8];
    end
    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    read_reg(9'h080, rd);
    check(rd, '0, "summary status after reset");
    for (int m = 0; m < 4; m++) begin
      read_reg(matcher_reg(m, 0), rd);
      check(rd, '0, "control word after reset");
    end
    read_reg(9'h100, rd);
    check(rd, '0, "hash after reset");

    check_dma_job(35, 40, "job with pattern");
    check_dma_job(133, 30, "job without pattern");

    write_reg(matcher_reg(1, 1), 32'h02f1);
    write_reg(matcher_reg(1, 2), 32'h00a7);
    write_reg(matcher_reg(3, 1), 32'h3ffe);
    write_reg(matcher_reg(3, 2), 32'h005c);
    read_reg(matcher_reg(1, 1), rd);
    check(rd, 32'h02f1, "matcher 1 length");
    read_reg(matcher_reg(1, 2), rd);
    check(rd, 32'h00a7, "matcher 1 address");
    read_reg(matcher_reg(3, 1), rd);
    check(rd, 32'h3ffe, "matcher 3 length");
    read_reg(matcher_reg(3, 2), rd);
    check(rd, 32'h005c, "matcher 3 address");
    run_job(0, 0, 3, kind, beats);
    exp_done[0]  = 1'b1;
    exp_match[0] = range_has_pattern(0, 3, pat_0, 4);
    read_reg(9'h080, rd);
    check(rd, {28'b0, exp_done | exp_match}, "summary status");

    beats0 = beats_seen;
    write_reg(matcher_reg(0, 1), 32'd2000);
    write_reg(matcher_reg(0, 2), 32'd16);
    write_reg(matcher_reg(0, 0), 32'h1);
    repeat (45) @(negedge clk);
    write_reg(matcher_reg(0, 0), 32'h10);
    wait_idle(0);
    beats = beats_seen - beats0;
    check(32'(beats < 2000), 32'h1, "stop cut the job short");
    read_reg(matcher_reg(0, 0), rd);
    check(rd, ctrl_word(1'b1, range_has_pattern(16, beats, pat_0, 4)), "status after stop");
    write_reg(matcher_reg(0, 1), 32'd0);  // Zero length gives no job, only the status clear
    write_reg(matcher_reg(0, 0), 32'h1);
    repeat (2) @(negedge clk);
    read_reg(matcher_reg(0, 0), rd);
    check(rd, '0, "status after new start");
    exp_done[0]  = 1'b0;
    exp_match[0] = 1'b0;
    read_reg(9'h080, rd);
    check(rd, {28'b0, exp_done | exp_match}, "summary status after clear");

    write_reg(9'h100, '0);
    nfed = 0;
    for (int f = 0; f < 8; f++) begin
      kind = int'($unsigned($random(seed)) % 3);
      data = $random(seed);
      write_reg(9'(9'h104 + kind * 4), data);
      for (int j = (kind == 2 ? 4 : kind + 1) - 1; j >= 0; j--) begin
        fed_bytes[nfed] = data[8*j +: 8];
        nfed++;
      end
    end
    read_reg(9'h100, rd);  // Lands while the last feed is still in flight
    check(rd, toeplitz_ref(nfed), "hash right after last feed");
    repeat (3) @(negedge clk);
    read_reg(9'h100, rd);
    check(rd, toeplitz_ref(nfed), "hash read later");
    write_reg(9'h100, '0);
    repeat (2) @(negedge clk);
    read_reg(9'h100, rd);
    check(rd, '0, "hash after clear");

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
design/accel_pkg.sv
design/pattern_matcher.sv
design/toeplitz_hash.sv
design/accel_regs.sv
design/accel_rd_dma.sv
design/accel_wrap.sv
test/accel_wrap_tb.sv
